// ==== common/disp_pkg.sv ====
`default_nettype none

package disp_pkg;

  // widths of the display subsystem
  localparam int unsigned word_w  = 32;
  localparam int unsigned addr_w  = 4;
  localparam int unsigned nib_w   = 4;
  localparam int unsigned seg_w   = 7;
  localparam int unsigned led_w   = 16;
  localparam int unsigned digit_w = 3;

  // number of seven-segment digits on the board
  localparam int unsigned num_digits = 8;

  // clock cycles spent on each digit, small for simulation
  localparam int unsigned scan_div = 4;

  typedef logic [word_w-1:0]     word_t;
  typedef logic [addr_w-1:0]     addr_t;
  typedef logic [nib_w-1:0]      nibble_t;

  // active low, bit 6 is segment a down to bit 0 for segment g
  typedef logic [seg_w-1:0]      seg_t;

  // active low, bit i enables digit i
  typedef logic [num_digits-1:0] anode_t;

  typedef logic [led_w-1:0]      led_t;
  typedef logic [digit_w-1:0]    digit_t;

  // register map
  localparam addr_t addr_disp = addr_t'(0);
  localparam addr_t addr_led  = addr_t'(1);

  // request as presented by the MMIO master
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } mmio_req_t;

  // single cycle write strobe into the register block
  typedef struct packed {
    logic  en;
    addr_t addr;
    word_t data;
  } reg_wr_t;

  // four-phase slave states
  typedef enum logic {
    idle,
    acked
  } bus_state_e;

endpackage

`default_nettype wire

// ==== design/bus_slave_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_slave_fsm
  import disp_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req,
  input  mmio_req_t mreq,
  input  word_t     rd_word,
  output logic      ack,
  output word_t     rdata,
  output reg_wr_t   wr,
  output addr_t     rd_addr
);

  bus_state_e state_q;
  bus_state_e state_d;
  logic       accept;
  logic       wr_en_q;
  addr_t      wr_addr_q;
  word_t      wr_data_q;

  // request seen for the first time
  assign accept = (state_q == idle) && req;

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (req)
          state_d = acked;
      end
      acked: begin
        // hold ack until the master lets go of req
        if (!req)
          state_d = idle;
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= idle;
      wr_en_q <= 1'b0;
      rdata   <= '0;
    end else begin
      state_q <= state_d;
      // one strobe per transaction, even when req is held long
      wr_en_q <= accept && mreq.we;
      if (accept)
        rdata <= rd_word;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr_q <= mreq.addr;
      wr_data_q <= mreq.wdata;
    end
  end

  assign ack     = (state_q == acked);
  assign wr      = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};
  // read path is combinational through the register block
  assign rd_addr = mreq.addr;

  ack_rise_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req));

  wr_strobe_single: assert property (
    @(posedge clk) disable iff (!rst_n) wr.en |=> !wr.en);

  ack_held_with_req: assert property (
    @(posedge clk) disable iff (!rst_n) (ack && req) |=> ack);

endmodule

`default_nettype wire

// ==== design/scan_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_timer
  import disp_pkg::*;
#(
  parameter int unsigned div = scan_div
) (
  input  logic clk,
  input  logic rst_n,
  output logic tick
);

  localparam int unsigned cnt_w = (div > 1) ? $clog2(div) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(div - 1);

  logic [cnt_w-1:0] cnt_q;

  // free running, wraps after div cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (cnt_q == cnt_last) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // high in the last cycle of each period
  assign tick = (cnt_q == cnt_last);

  tick_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) ((div > 1) && tick) |=> !tick);

endmodule

`default_nettype wire

// ==== display/display_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_regs
  import disp_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  reg_wr_t wr,
  input  addr_t   rd_addr,
  input  logic    debug,
  input  word_t   debug_word,
  output word_t   rd_word,
  output word_t   shown,
  output led_t    led
);

  word_t disp_q;
  led_t  led_q;

  // write decode, unmapped addresses are dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      disp_q <= '0;
      led_q  <= '0;
    end else if (wr.en) begin
      case (wr.addr)
        addr_disp: disp_q <= wr.data;
        addr_led:  led_q  <= wr.data[led_w-1:0];
        default: begin
        end
      endcase
    end
  end

  // read mux
  always_comb begin
    case (rd_addr)
      addr_disp: rd_word = disp_q;
      addr_led:  rd_word = word_t'(led_q);
      default:   rd_word = '0;
    endcase
  end

  // debug word overrides the display register
  assign shown = debug ? debug_word : disp_q;

  assign led = led_q;

endmodule

`default_nettype wire

// ==== display/seg_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg_scanner
  import disp_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   tick,
  input  word_t  shown,
  output anode_t an,
  output seg_t   sev
);

  localparam digit_t digit_last = digit_t'(num_digits - 1);

  digit_t  digit_q;
  nibble_t nib;

  // hex to segments, active low abcdefg
  function automatic seg_t hex_to_seg(input nibble_t value);
    seg_t seg;
    case (value)
      4'h0: seg = 7'b0000001;
      4'h1: seg = 7'b1001111;
      4'h2: seg = 7'b0010010;
      4'h3: seg = 7'b0000110;
      4'h4: seg = 7'b1001100;
      4'h5: seg = 7'b0100100;
      4'h6: seg = 7'b0100000;
      4'h7: seg = 7'b0001111;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0000100;
      4'ha: seg = 7'b0001000;
      4'hb: seg = 7'b1100000;
      4'hc: seg = 7'b0110001;
      4'hd: seg = 7'b1000010;
      4'he: seg = 7'b0110000;
      4'hf: seg = 7'b0111000;
      default: seg = 7'b0000000;
    endcase
    return seg;
  endfunction

  // digit index, steps once per scan tick
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      digit_q <= '0;
    end else if (tick) begin
      if (digit_q == digit_last)
        digit_q <= '0;
      else
        digit_q <= digit_q + 1'b1;
    end
  end

  // digit i pulls anode bit i low
  assign an = ~(anode_t'(1) << digit_q);

  // nibble i sits at bits 4i+3 down to 4i
  assign nib = shown[digit_q*nib_w +: nib_w];

  assign sev = hex_to_seg(nib);

  one_anode_low: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot(~an));

endmodule

`default_nettype wire

// ==== design/display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_top
  import disp_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req,
  input  mmio_req_t mreq,
  output logic      ack,
  output word_t     rdata,
  input  logic      debug,
  input  word_t     debug_word,
  output anode_t    an,
  output seg_t      sev,
  output led_t      led
);

  reg_wr_t wr;
  addr_t   rd_addr;
  word_t   rd_word;
  word_t   shown;
  logic    tick;

  bus_slave_fsm bus_slave_fsm_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .mreq    (mreq),
    .rd_word (rd_word),
    .ack     (ack),
    .rdata   (rdata),
    .wr      (wr),
    .rd_addr (rd_addr)
  );

  display_regs display_regs_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr         (wr),
    .rd_addr    (rd_addr),
    .debug      (debug),
    .debug_word (debug_word),
    .rd_word    (rd_word),
    .shown      (shown),
    .led        (led)
  );

  // digit rate
  scan_timer #(
    .div (scan_div)
  ) scan_timer_i (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (tick)
  );

  seg_scanner seg_scanner_i (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (tick),
    .shown (shown),
    .an    (an),
    .sev   (sev)
  );

endmodule

`default_nettype wire

// ==== bench/display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_tb
  import disp_pkg::*;
();

  localparam int unsigned period     = 20;
  localparam int unsigned n_trans    = 200;
  // generous bound on the cycles one handshake takes
  localparam int unsigned trans_max  = 12;
  localparam int unsigned rot_cycles = num_digits * scan_div;
  // 3 plain rotations, 3 debug rotations, 1 back on the register
  localparam int unsigned scan_cycles = 7 * rot_cycles + 10;
  localparam longint unsigned wd_ns =
    2 * (n_trans * trans_max + scan_cycles + 20) * period;

  logic      clk;
  logic      rst_n;
  logic      req;
  mmio_req_t mreq;
  logic      ack;
  word_t     rdata;
  logic      debug;
  word_t     debug_word;
  anode_t    an;
  seg_t      sev;
  led_t      led;

  // reference model state
  word_t       disp_m;
  led_t        led_m;
  digit_t      digit_m;
  int unsigned scan_cnt;
  logic        scan_on;
  logic        req_prev;
  logic        ack_prev;
  word_t       shown_m;
  anode_t      an_m;

  display_top display_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .mreq       (mreq),
    .ack        (ack),
    .rdata      (rdata),
    .debug      (debug),
    .debug_word (debug_word),
    .an         (an),
    .sev        (sev),
    .led        (led)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // reference decode table in active low abcdefg
  function automatic seg_t segments_for(input nibble_t n);
    seg_t s;
    case (n)
      4'h0: s = 7'b0000001;
      4'h1: s = 7'b1001111;
      4'h2: s = 7'b0010010;
      4'h3: s = 7'b0000110;
      4'h4: s = 7'b1001100;
      4'h5: s = 7'b0100100;
      4'h6: s = 7'b0100000;
      4'h7: s = 7'b0001111;
      4'h8: s = 7'b0000000;
      4'h9: s = 7'b0000100;
      4'ha: s = 7'b0001000;
      4'hb: s = 7'b1100000;
      4'hc: s = 7'b0110001;
      4'hd: s = 7'b1000010;
      4'he: s = 7'b0110000;
      default: s = 7'b0111000;
    endcase
    return s;
  endfunction

  function automatic word_t model_read(input addr_t a);
    if (a == addr_disp)
      return disp_m;
    else if (a == addr_led)
      return {16'h0000, led_m};
    else
      return '0;
  endfunction

  // one four-phase transaction with hold cycles of back-pressure
  task automatic run_transaction(input logic is_write, input addr_t address,
                                 input word_t value, input int unsigned hold);
    word_t exp_rd;
    exp_rd = model_read(address);
    @(posedge clk);
    req  <= 1'b1;
    mreq <= '{we: is_write, addr: address, wdata: value};
    do @(negedge clk); while (!ack);
    // read returns the contents from before this transaction
    check_eq("rdata", rdata, exp_rd);
    repeat (hold) @(negedge clk);
    @(posedge clk);
    req <= 1'b0;
    do @(negedge clk); while (ack);
    if (is_write) begin
      if (address == addr_disp)
        disp_m = value;
      else if (address == addr_led)
        led_m = value[15:0];
    end
    check_eq("led", led, led_m);
  endtask

  // digit counter stepping every scan_div cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      scan_cnt <= 0;
      digit_m  <= '0;
    end else if (scan_cnt == scan_div - 1) begin
      scan_cnt <= 0;
      digit_m  <= digit_m + 1'b1;
    end else begin
      scan_cnt <= scan_cnt + 1;
    end
  end

  // handshake rules checked every cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (req && !req_prev)
        check_eq("ack at req rise", ack, 1'b0);
      if (ack && !ack_prev)
        check_eq("req at ack rise", req, 1'b1);
      if (ack_prev && req_prev)
        check_eq("ack while req held", ack, 1'b1);
    end
    req_prev = req;
    ack_prev = ack;
  end

  always @(negedge clk) begin
    int unsigned k;
    if (scan_on) begin
      shown_m = debug ? debug_word : disp_m;
      // only the scanned digit has its anode pulled low
      for (k = 0; k < num_digits; k++)
        an_m[k] = (k != digit_m);
      check_eq("an", an, an_m);
      check_eq("sev", sev, segments_for(shown_m[digit_m*nib_w +: nib_w]));
    end
  end

  initial begin
    #(wd_ns);
    $display("timeout: the simulation ran longer than the tests need");
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int unsigned i;
    logic        we;
    addr_t       addr;
    word_t       data;
    int unsigned hold;
    void'($urandom(2));
    rst_n      = 1'b0;
    req        = 1'b0;
    mreq       = '0;
    debug      = 1'b0;
    debug_word = '0;
    scan_on    = 1'b0;
    req_prev   = 1'b0;
    ack_prev   = 1'b0;
    disp_m     = '0;
    led_m      = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq("ack", ack, 1'b0);
    check_eq("rdata", rdata, 32'h0);
    check_eq("led", led, 16'h0000);
    check_eq("an", an, 8'hfe);
    check_eq("sev", sev, 7'b0000001);

    for (i = 0; i < n_trans; i++) begin
      we   = 1'($urandom_range(1));
      addr = addr_t'($urandom_range(3));
      data = $urandom();
      hold = $urandom_range(2);
      run_transaction(we, addr, data, hold);
    end
    // known nonzero pattern for the scan
    run_transaction(1'b1, addr_disp, $urandom() | 32'h1, 0);

    @(posedge clk);
    scan_on <= 1'b1;
    repeat (3 * rot_cycles) @(posedge clk);

    for (i = 0; i < 3; i++) begin
      debug      <= 1'b1;
      debug_word <= $urandom();
      repeat (rot_cycles) @(posedge clk);
    end
    debug <= 1'b0;
    repeat (rot_cycles) @(posedge clk);
    scan_on <= 1'b0;
    @(negedge clk);

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/disp_pkg.sv
design/bus_slave_fsm.sv
design/scan_timer.sv
display/display_regs.sv
display/seg_scanner.sv
design/display_top.sv
bench/display_tb.sv

// ==== Bender.yml ====
package:
  name: display_subsystem

dependencies: {}

sources:
  # shared package first
  - common/disp_pkg.sv

  # bus slave and scan timing
  - files:
      - design/bus_slave_fsm.sv
      - design/scan_timer.sv

  # display block
  - files:
      - display/display_regs.sv
      - display/seg_scanner.sv

  # top level
  - design/display_top.sv

  # testbench
  - target: test
    files:
      - bench/display_tb.sv
